// File: filelist.f
+incdir+.
serv_pkg.sv
serv_state.sv
serv_decode.sv
serv_immdec.sv
serv_alu.sv
serv_ctrl.sv
serv_rf_if.sv
serv_top.sv
tb_serv_top.sv

// File: Bender.yml
package:
  name: serv_core

sources:
  - include_dirs:
      - .
    files:
      - serv_pkg.sv
      - serv_state.sv
      - serv_decode.sv
      - serv_immdec.sv
      - serv_alu.sv
      - serv_ctrl.sv
      - serv_rf_if.sv
      - serv_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_serv_top.sv

// File: tb_serv_top.sv
/*
 * Random-instruction testbench for the serial core, with its own ISA model.
 * Only OP, OP-IMM, LUI, AUIPC and JAL are issued, and JAL offsets stay word aligned.
 * The instruction memory returns a fresh random word on every fetch.
 */
`timescale 1ns/1ps
`default_nettype none

`include "serv_defines.svh"

module tb_serv_top;
   import serv_pkg::*;

   localparam int          CLK_PERIOD   = 4;
   localparam int          N_INSN       = 400;
   localparam int          CYC_PER_INSN = 50;
   localparam logic [31:0] SEED         = 32'h2d89_b168;

   typedef enum int {
      K_ADD, K_SUB, K_AND, K_OR, K_XOR,
      K_ADDI, K_ANDI, K_ORI, K_XORI,
      K_LUI, K_AUIPC, K_JAL
   } kind_t;

   logic        clk;
   logic        i_rst;
   logic [31:0] o_ibus_adr;
   logic        o_ibus_cyc;
   logic [31:0] i_ibus_rdt;
   logic        i_ibus_ack;
   logic        o_rf_rreq;
   logic        i_rf_ready;
   reg_addr_t   o_rreg0;
   reg_addr_t   o_rreg1;
   logic        i_rdata0;
   logic        i_rdata1;
   logic        o_wen0;
   reg_addr_t   o_wreg0;
   logic        o_wdata0;

   // Register file and PC of the ISA model
   logic [31:0] regs [32];
   logic [31:0] pc;

   serv_top i_serv_top (
      .clk        (clk),
      .i_rst      (i_rst),
      .o_ibus_adr (o_ibus_adr),
      .o_ibus_cyc (o_ibus_cyc),
      .i_ibus_rdt (i_ibus_rdt),
      .i_ibus_ack (i_ibus_ack),
      .o_rf_rreq  (o_rf_rreq),
      .i_rf_ready (i_rf_ready),
      .o_rreg0    (o_rreg0),
      .o_rreg1    (o_rreg1),
      .i_rdata0   (i_rdata0),
      .i_rdata1   (i_rdata1),
      .o_wen0     (o_wen0),
      .o_wreg0    (o_wreg0),
      .o_wdata0   (o_wdata0)
   );

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("TEST FAILED");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check_fetch(input logic [31:0] exp_adr);
      if (o_ibus_adr !== exp_adr)
         abort_run($sformatf("** Error at %0d ns: fetch address %h, expected %h",
                             $time, o_ibus_adr, exp_adr));
   endtask

   task automatic check_write(input reg_addr_t exp_rd, input logic [31:0] exp_val,
                              input reg_addr_t got_rd, input logic [31:0] got_val);
      if (got_rd !== exp_rd || got_val !== exp_val)
         abort_run($sformatf("** Error at %0d ns: wrote x%0d = %h, expected x%0d = %h",
                             $time, got_rd, got_val, exp_rd, exp_val));
   endtask

   task automatic check_rreq(input reg_addr_t exp_rs1, input reg_addr_t exp_rs2);
      if (o_rreg0 !== exp_rs1 || o_rreg1 !== exp_rs2)
         abort_run($sformatf("** Error at %0d ns: reads x%0d/x%0d, expected x%0d/x%0d",
                             $time, o_rreg0, o_rreg1, exp_rs1, exp_rs2));
   endtask

   task automatic check_strobes(input logic exp_cyc, input logic exp_rreq,
                                input logic exp_wen);
      if (o_ibus_cyc !== exp_cyc || o_rf_rreq !== exp_rreq || o_wen0 !== exp_wen)
         abort_run($sformatf("** Error at %0d ns: cyc/rreq/wen = %b%b%b, expected %b%b%b",
                             $time, o_ibus_cyc, o_rf_rreq, o_wen0,
                             exp_cyc, exp_rreq, exp_wen));
   endtask

   task automatic fill_regs();
      int r;
      regs[0] = '0;
      for (r = 1; r < 32; r++)
         regs[r] = $urandom;
   endtask

   // Random instruction with its expected result and next PC
   task automatic make_insn(output logic [31:0] word, output reg_addr_t rd,
                            output logic [31:0] exp_val, output logic [31:0] next_pc);
      kind_t       kind;
      reg_addr_t   rs1;
      reg_addr_t   rs2;
      logic [11:0] imm12;
      logic [19:0] imm20;
      logic [20:0] joff;
      logic [31:0] op_b;
      logic [2:0]  f3;
      logic        is_imm;
      kind  = kind_t'($urandom_range(0, 11));
      rd    = reg_addr_t'($urandom_range(0, 31));
      if ($urandom_range(0, 7) == 0)
         rd = '0;
      rs1   = reg_addr_t'($urandom_range(0, 31));
      rs2   = reg_addr_t'($urandom_range(0, 31));
      imm12 = 12'($urandom);
      imm20 = 20'($urandom);
      joff  = 21'($urandom);
      joff[1:0] = 2'b00;
      is_imm  = (kind >= K_ADDI) && (kind <= K_XORI);
      op_b    = is_imm ? {{20{imm12[11]}}, imm12} : regs[rs2];
      f3      = 3'b000;
      next_pc = pc + 32'd4;
      case (kind)
         K_ADD, K_ADDI: exp_val = regs[rs1] + op_b;
         K_SUB:         exp_val = regs[rs1] - op_b;
         K_XOR, K_XORI: begin
            f3      = 3'b100;
            exp_val = regs[rs1] ^ op_b;
         end
         K_OR, K_ORI: begin
            f3      = 3'b110;
            exp_val = regs[rs1] | op_b;
         end
         K_AND, K_ANDI: begin
            f3      = 3'b111;
            exp_val = regs[rs1] & op_b;
         end
         K_LUI:   exp_val = {imm20, 12'b0};
         K_AUIPC: exp_val = pc + {imm20, 12'b0};
         default: begin
            exp_val = pc + 32'd4;
            next_pc = pc + {{11{joff[20]}}, joff};
         end
      endcase
      if (kind == K_LUI)
         word = {imm20, rd, `SERV_OP_LUI};
      else if (kind == K_AUIPC)
         word = {imm20, rd, `SERV_OP_AUIPC};
      else if (kind == K_JAL)
         word = {joff[20], joff[10:1], joff[11], joff[19:12], rd, `SERV_OP_JAL};
      else if (is_imm)
         word = {imm12, rs1, f3, rd, `SERV_OP_OP_IMM};
      else
         word = {(kind == K_SUB) ? 7'b0100000 : 7'b0000000, rs2, rs1, f3, rd, `SERV_OP_OP};
   endtask

   // One instruction from fetch to the last run cycle
   task automatic execute_insn();
      logic [31:0] word;
      reg_addr_t   rd;
      logic [31:0] exp_val;
      logic [31:0] next_pc;
      logic [31:0] rs1_val;
      logic [31:0] rs2_val;
      logic [31:0] got_val;
      reg_addr_t   got_rd;
      int          ack_dly;
      int          rdy_dly;
      int          k;
      make_insn(word, rd, exp_val, next_pc);
      ack_dly = $urandom_range(0, 3);
      rdy_dly = $urandom_range(1, 4);
      got_val = '0;
      got_rd  = '0;
      repeat (ack_dly) begin
         @(posedge clk);
         check_strobes(1'b1, 1'b0, 1'b0);
         check_fetch(pc);
      end
      i_ibus_ack <= 1'b1;
      i_ibus_rdt <= word;
      @(posedge clk);
      check_strobes(1'b1, 1'b0, 1'b0);
      check_fetch(pc);
      i_ibus_ack <= 1'b0;
      i_ibus_rdt <= $urandom;
      @(posedge clk);
      check_strobes(1'b0, 1'b1, 1'b0);
      check_rreq(reg_addr_t'(word[19:15]), reg_addr_t'(word[24:20]));
      // Register file answers the addresses the core asked for
      rs1_val = regs[o_rreg0];
      rs2_val = regs[o_rreg1];
      repeat (rdy_dly - 1) begin
         @(posedge clk);
         check_strobes(1'b0, 1'b0, 1'b0);
      end
      i_rf_ready <= 1'b1;
      @(posedge clk);
      check_strobes(1'b0, 1'b0, 1'b0);
      i_rf_ready <= 1'b0;
      for (k = 0; k < `SERV_XLEN; k++) begin
         i_rdata0 <= rs1_val[k];
         i_rdata1 <= rs2_val[k];
         @(posedge clk);
         check_strobes(1'b0, 1'b0, rd != 5'd0);
         if (o_wen0) begin
            got_val[k] = o_wdata0;
            got_rd     = o_wreg0;
         end
      end
      i_rdata0 <= 1'($urandom);
      i_rdata1 <= 1'($urandom);
      if (rd != 5'd0) begin
         check_write(rd, exp_val, got_rd, got_val);
         regs[rd] = exp_val;
      end
      pc = next_pc;
   endtask

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   initial begin
      #(N_INSN * CYC_PER_INSN * CLK_PERIOD);
      abort_run("Timeout: the core did not finish all instructions in the expected time");
   end

   initial begin
      void'($urandom(SEED));
      i_rst      <= 1'b1;
      i_ibus_ack <= 1'b0;
      i_ibus_rdt <= '0;
      i_rf_ready <= 1'b0;
      i_rdata0   <= 1'b0;
      i_rdata1   <= 1'b0;
      fill_regs();
      pc = `SERV_RESET_PC;
      repeat (2) @(posedge clk);
      i_rst <= 1'b0;
      repeat (N_INSN) execute_insn();
      $display("TEST OK");
      $finish;
   end

endmodule

`default_nettype wire

// File: serv_top.sv
/*
 * Bit-serial RV32I core: ADD, SUB, AND, OR, XOR, their immediate forms,
 * LUI, AUIPC and JAL. Other opcodes give undefined results.
 * Register data moves one bit per cycle, LSB first, over 32 run cycles.
 */
`timescale 1ns/1ps
`default_nettype none

module serv_top (
   input  logic                clk,
   input  logic                i_rst,
   output logic [31:0]         o_ibus_adr,
   output logic                o_ibus_cyc,
   input  logic [31:0]         i_ibus_rdt,
   input  logic                i_ibus_ack,
   output logic                o_rf_rreq,
   input  logic                i_rf_ready,
   output serv_pkg::reg_addr_t o_rreg0,
   output serv_pkg::reg_addr_t o_rreg1,
   input  logic                i_rdata0,
   input  logic                i_rdata1,
   output logic                o_wen0,
   output serv_pkg::reg_addr_t o_wreg0,
   output logic                o_wdata0
);
   import serv_pkg::*;

   ctrl_t     dec_ctrl;
   reg_addr_t rd_addr;
   logic      cnt_en;
   logic      cnt0;
   logic      cnt_done;
   logic      imm;
   logic      alu_rd;
   logic      ctrl_rd;

   serv_state state (
      .clk        (clk),
      .i_rst      (i_rst),
      .i_ibus_ack (i_ibus_ack),
      .i_rf_ready (i_rf_ready),
      .o_ibus_cyc (o_ibus_cyc),
      .o_rf_rreq  (o_rf_rreq),
      .o_cnt_en   (cnt_en),
      .o_cnt0     (cnt0),
      .o_cnt_done (cnt_done)
   );

   serv_decode decode (
      .clk        (clk),
      .i_ibus_rdt (i_ibus_rdt),
      .i_ibus_ack (i_ibus_ack),
      .o_ctrl     (dec_ctrl),
      .o_rs1_addr (o_rreg0),
      .o_rs2_addr (o_rreg1),
      .o_rd_addr  (rd_addr)
   );

   serv_immdec immdec (
      .clk        (clk),
      .i_ibus_rdt (i_ibus_rdt),
      .i_ibus_ack (i_ibus_ack),
      .i_cnt_en   (cnt_en),
      .i_imm_type (dec_ctrl.imm_type),
      .o_imm      (imm)
   );

   serv_alu alu (
      .clk      (clk),
      .i_cnt_en (cnt_en),
      .i_cnt0   (cnt0),
      .i_ctrl   (dec_ctrl),
      .i_rs1    (i_rdata0),
      .i_rs2    (i_rdata1),
      .i_imm    (imm),
      .o_rd     (alu_rd)
   );

   serv_ctrl ctrl (
      .clk        (clk),
      .i_rst      (i_rst),
      .i_cnt_en   (cnt_en),
      .i_cnt0     (cnt0),
      .i_cnt_done (cnt_done),
      .i_ctrl     (dec_ctrl),
      .i_imm      (imm),
      .o_ibus_adr (o_ibus_adr),
      .o_rd       (ctrl_rd)
   );

   serv_rf_if rf_if (
      .i_cnt_en  (cnt_en),
      .i_ctrl    (dec_ctrl),
      .i_rd_addr (rd_addr),
      .i_alu_rd  (alu_rd),
      .i_ctrl_rd (ctrl_rd),
      .i_imm     (imm),
      .o_wen0    (o_wen0),
      .o_wreg0   (o_wreg0),
      .o_wdata0  (o_wdata0)
   );

endmodule

`default_nettype wire

// File: serv_rf_if.sv
/*
 * Write port of the external register file.
 * Writes happen only in run cycles, never to x0.
 */
`timescale 1ns/1ps
`default_nettype none

module serv_rf_if (
   input  logic                i_cnt_en,
   input  serv_pkg::ctrl_t     i_ctrl,
   input  serv_pkg::reg_addr_t i_rd_addr,
   input  logic                i_alu_rd,
   input  logic                i_ctrl_rd,
   input  logic                i_imm,
   output logic                o_wen0,
   output serv_pkg::reg_addr_t o_wreg0,
   output logic                o_wdata0
);
   import serv_pkg::*;

   always_comb begin
      case (i_ctrl.rd_sel)
         RD_CTRL: o_wdata0 = i_ctrl_rd;
         // LUI writes the immediate as is
         RD_IMM:  o_wdata0 = i_imm;
         default: o_wdata0 = i_alu_rd;
      endcase
   end

   assign o_wen0  = i_cnt_en & i_ctrl.rd_wr;
   assign o_wreg0 = i_rd_addr;

endmodule

`default_nettype wire

// File: serv_ctrl.sv
/*
 * PC register, shifted LSB first during the run and held otherwise.
 * The next PC is PC+imm for JAL and PC+4 for everything else.
 * A JAL offset that is not word aligned is not supported.
 */
`timescale 1ns/1ps
`default_nettype none

`include "serv_defines.svh"

module serv_ctrl (
   input  logic            clk,
   input  logic            i_rst,
   input  logic            i_cnt_en,
   input  logic            i_cnt0,
   input  logic            i_cnt_done,
   input  serv_pkg::ctrl_t i_ctrl,
   input  logic            i_imm,
   output logic [31:0]     o_ibus_adr,
   output logic            o_rd
);

   logic [31:0] pc;
   logic [1:0]  cnt_dly;
   logic        cnt2;
   logic        plus4;
   logic        plus4_cy_q;
   logic        rel_a;
   logic        pc_imm;
   logic        rel_cy_q;
   logic        new_pc;

   // Marks bit 2 for the +4
   assign cnt2   = cnt_dly[1];
   assign plus4  = pc[0] ^ cnt2 ^ plus4_cy_q;

   assign rel_a  = i_ctrl.pc_rel & pc[0];
   assign pc_imm = rel_a ^ i_imm ^ rel_cy_q;

   assign new_pc = i_ctrl.jal ? pc_imm : plus4;
   assign o_rd   = i_ctrl.utype ? pc_imm : plus4;

   always_ff @(posedge clk) begin
      if (i_rst) begin
         pc         <= `SERV_RESET_PC;
         cnt_dly    <= 2'b00;
         plus4_cy_q <= 1'b0;
         rel_cy_q   <= 1'b0;
      end else if (i_cnt_en) begin
         pc      <= {new_pc, pc[31:1]};
         cnt_dly <= {cnt_dly[0], i_cnt0};
         // Carries cleared for the next instruction
         plus4_cy_q <= i_cnt_done ? 1'b0 :
                       (pc[0] & cnt2) | (plus4_cy_q & (pc[0] ^ cnt2));
         rel_cy_q   <= i_cnt_done ? 1'b0 :
                       (rel_a & i_imm) | (rel_cy_q & (rel_a ^ i_imm));
      end
   end

   assign o_ibus_adr = pc;

   a_pc_aligned : assert property (@(posedge clk) disable iff (i_rst)
      i_cnt_done |=> (o_ibus_adr[1:0] == 2'b00))
      else $error("next fetch address not word aligned");

endmodule

`default_nettype wire

// File: serv_alu.sv
/*
 * Serial ALU for add, subtract, and, or and xor.
 * Subtraction inverts operand b and starts the carry at one.
 */
`timescale 1ns/1ps
`default_nettype none

module serv_alu (
   input  logic            clk,
   input  logic            i_cnt_en,
   input  logic            i_cnt0,
   input  serv_pkg::ctrl_t i_ctrl,
   input  logic            i_rs1,
   input  logic            i_rs2,
   input  logic            i_imm,
   output logic            o_rd
);

   logic op_b;
   logic b_inv;
   logic carry_in;
   logic carry_q;
   logic sum;

   assign op_b     = i_ctrl.op_b_imm ? i_imm : i_rs2;
   assign b_inv    = op_b ^ i_ctrl.alu_sub;
   // Carry restarts on bit 0
   assign carry_in = i_cnt0 ? i_ctrl.alu_sub : carry_q;
   assign sum      = i_rs1 ^ b_inv ^ carry_in;

   always_ff @(posedge clk) begin
      if (i_cnt_en)
         carry_q <= (i_rs1 & b_inv) | (carry_in & (i_rs1 ^ b_inv));
   end

   always_comb begin
      case (i_ctrl.bool_op)
         2'b01:   o_rd = i_rs1 ^ op_b;
         2'b10:   o_rd = i_rs1 | op_b;
         2'b11:   o_rd = i_rs1 & op_b;
         default: o_rd = sum;
      endcase
   end

endmodule

`default_nettype wire

// File: serv_immdec.sv
/*
 * Serial immediate, LSB first, one bit per run cycle.
 * The raw word is loaded on ack and rearranged in the next cycle,
 * once the decoded immediate type is valid.
 */
`timescale 1ns/1ps
`default_nettype none

module serv_immdec (
   input  logic                clk,
   input  serv_pkg::insn_u     i_ibus_rdt,
   input  logic                i_ibus_ack,
   input  logic                i_cnt_en,
   input  serv_pkg::imm_type_t i_imm_type,
   output logic                o_imm
);
   import serv_pkg::*;

   logic [31:0] imm_q;
   logic        fmt_pending;
   insn_u       raw;
   logic [31:0] imm_word;

   assign raw = imm_q;

   always_comb begin
      case (i_imm_type)
         IMM_U:   imm_word = {raw.u.imm20, 12'b0};
         IMM_J:   imm_word = {{12{raw.u.imm20[19]}}, raw.u.imm20[7:0],
                              raw.u.imm20[8], raw.u.imm20[18:9], 1'b0};
         default: imm_word = {{20{raw.i.imm12[11]}}, raw.i.imm12};
      endcase
   end

   always_ff @(posedge clk) begin
      fmt_pending <= i_ibus_ack;
      if (i_ibus_ack)
         imm_q <= i_ibus_rdt;
      else if (fmt_pending)
         imm_q <= imm_word;
      else if (i_cnt_en)
         imm_q <= {imm_q[31], imm_q[31:1]};
   end

   assign o_imm = imm_q[0];

endmodule

`default_nettype wire

// File: serv_decode.sv
/*
 * Captures the fetched word on ack and decodes it into the control struct.
 * Opcodes outside OP, OP-IMM, LUI, AUIPC and JAL give undefined controls.
 */
`timescale 1ns/1ps
`default_nettype none

`include "serv_defines.svh"

module serv_decode (
   input  logic                clk,
   input  serv_pkg::insn_u     i_ibus_rdt,
   input  logic                i_ibus_ack,
   output serv_pkg::ctrl_t     o_ctrl,
   output serv_pkg::reg_addr_t o_rs1_addr,
   output serv_pkg::reg_addr_t o_rs2_addr,
   output serv_pkg::reg_addr_t o_rd_addr
);
   import serv_pkg::*;

   insn_u insn;

   function automatic logic [1:0] bool_sel(input logic [2:0] funct3);
      logic [1:0] sel;
      case (funct3)
         3'b100:  sel = 2'b01;
         3'b110:  sel = 2'b10;
         3'b111:  sel = 2'b11;
         default: sel = 2'b00;
      endcase
      return sel;
   endfunction

   always_ff @(posedge clk) begin
      if (i_ibus_ack)
         insn <= i_ibus_rdt;
   end

   always_comb begin
      o_ctrl          = '0;
      o_ctrl.rd_sel   = RD_ALU;
      o_ctrl.imm_type = IMM_I;
      case (insn.r.opcode)
         `SERV_OP_OP: begin
            // SUB is ADD with funct7 bit 5 set
            o_ctrl.alu_sub = (insn.r.funct3 == 3'b000) & insn.r.funct7[5];
            o_ctrl.bool_op = bool_sel(insn.r.funct3);
         end
         `SERV_OP_OP_IMM: begin
            o_ctrl.op_b_imm = 1'b1;
            o_ctrl.bool_op  = bool_sel(insn.i.funct3);
         end
         `SERV_OP_LUI: begin
            o_ctrl.rd_sel   = RD_IMM;
            o_ctrl.utype    = 1'b1;
            o_ctrl.imm_type = IMM_U;
         end
         `SERV_OP_AUIPC: begin
            o_ctrl.rd_sel   = RD_CTRL;
            o_ctrl.utype    = 1'b1;
            o_ctrl.pc_rel   = 1'b1;
            o_ctrl.imm_type = IMM_U;
         end
         `SERV_OP_JAL: begin
            o_ctrl.rd_sel   = RD_CTRL;
            o_ctrl.jal      = 1'b1;
            o_ctrl.pc_rel   = 1'b1;
            o_ctrl.imm_type = IMM_J;
         end
         default: ;
      endcase
      // x0 stays zero
      o_ctrl.rd_wr = |insn.u.rd;
   end

   assign o_rs1_addr = insn.i.rs1;
   assign o_rs2_addr = insn.r.rs2;
   assign o_rd_addr  = insn.u.rd;

endmodule

`default_nettype wire

// File: serv_state.sv
/*
 * Phase sequencer: fetch, register request, wait, then 32 run cycles.
 * i_rf_ready must come at least one cycle after the o_rf_rreq pulse.
 * Only one instruction is in flight at any time.
 */
`timescale 1ns/1ps
`default_nettype none

`include "serv_defines.svh"

module serv_state (
   input  logic clk,
   input  logic i_rst,
   input  logic i_ibus_ack,
   input  logic i_rf_ready,
   output logic o_ibus_cyc,
   output logic o_rf_rreq,
   output logic o_cnt_en,
   output logic o_cnt0,
   output logic o_cnt_done
);

   typedef enum logic [1:0] {
      PH_FETCH,
      PH_REQ,
      PH_WAIT,
      PH_RUN
   } phase_t;

   phase_t     phase;
   logic [4:0] cnt;

   always_ff @(posedge clk) begin
      if (i_rst) begin
         phase <= PH_FETCH;
         cnt   <= '0;
      end else begin
         case (phase)
            PH_FETCH: if (i_ibus_ack) phase <= PH_REQ;
            PH_REQ:   phase <= PH_WAIT;
            PH_WAIT:  if (i_rf_ready) phase <= PH_RUN;
            default: begin
               // Wraps back to zero after the last bit
               cnt <= cnt + 5'd1;
               if (o_cnt_done)
                  phase <= PH_FETCH;
            end
         endcase
      end
   end

   assign o_ibus_cyc = (phase == PH_FETCH);
   assign o_rf_rreq  = (phase == PH_REQ);
   assign o_cnt_en   = (phase == PH_RUN);
   assign o_cnt0     = o_cnt_en && (cnt == 5'd0);
   assign o_cnt_done = o_cnt_en && (cnt == 5'(`SERV_XLEN - 1));

   // Ack only answers a pending fetch
   a_ack_in_fetch : assert property (@(posedge clk) disable iff (i_rst)
      i_ibus_ack |-> o_ibus_cyc)
      else $error("instruction bus ack without a fetch");

   a_ready_in_wait : assert property (@(posedge clk) disable iff (i_rst)
      i_rf_ready |-> (phase == PH_WAIT))
      else $error("register file ready without a pending request");

endmodule

`default_nettype wire

// File: serv_pkg.sv
/*
 * Instruction formats and decoded controls of the serial core.
 * Register numbers are 5 bits; there is no CSR address space.
 */
`default_nettype none

`include "serv_defines.svh"

package serv_pkg;

   typedef logic [4:0] reg_addr_t;

   typedef struct packed {
      logic [6:0] funct7;
      reg_addr_t  rs2;
      reg_addr_t  rs1;
      logic [2:0] funct3;
      reg_addr_t  rd;
      logic [6:0] opcode;
   } r_fmt_t;

   typedef struct packed {
      logic [11:0] imm12;
      reg_addr_t   rs1;
      logic [2:0]  funct3;
      reg_addr_t   rd;
      logic [6:0]  opcode;
   } i_fmt_t;

   // J scrambles the upper 20 bits that U uses as is
   typedef struct packed {
      logic [`SERV_XLEN-13:0] imm20;
      reg_addr_t              rd;
      logic [6:0]             opcode;
   } u_fmt_t;

   typedef union packed {
      r_fmt_t r;
      i_fmt_t i;
      u_fmt_t u;
   } insn_u;

   typedef enum logic [1:0] {
      RD_ALU  = 2'd0,
      RD_CTRL = 2'd1,
      RD_IMM  = 2'd2
   } rd_sel_t;

   typedef enum logic [1:0] {
      IMM_I = 2'd0,
      IMM_U = 2'd1,
      IMM_J = 2'd2
   } imm_type_t;

   // bool_op values 00 add, 01 xor, 10 or and 11 and
   typedef struct packed {
      logic       alu_sub;
      logic [1:0] bool_op;
      rd_sel_t    rd_sel;
      logic       op_b_imm;
      logic       jal;
      logic       utype;
      logic       pc_rel;
      imm_type_t  imm_type;
      logic       rd_wr;
   } ctrl_t;

endpackage

`default_nettype wire

// File: serv_defines.svh
/*
 * Shared constants of the bit-serial core.
 * The run length equals the data length and must stay 32.
 * Only the five opcodes listed here are decoded.
 */
`ifndef SERV_DEFINES_SVH
`define SERV_DEFINES_SVH

// First fetch address after reset
`define SERV_RESET_PC 32'h0000_0000

// Data length, also the number of run cycles
`define SERV_XLEN 32

// Opcodes of the kept instructions
`define SERV_OP_OP     7'b0110011
`define SERV_OP_OP_IMM 7'b0010011
`define SERV_OP_LUI    7'b0110111
`define SERV_OP_AUIPC  7'b0010111
`define SERV_OP_JAL    7'b1101111

`endif
